/* bpred_consts.svh */
`ifndef BPRED_CONSTS_SVH
`define BPRED_CONSTS_SVH

// ------------------------------------------------------------
// branch prediction sizing
// ------------------------------------------------------------

// virtual address width
`define BP_VLEN 32

// halfword slots covered by one fetch address
`define BP_INSTR_PER_FETCH 2

// history table entries, split into rows of BP_INSTR_PER_FETCH
`define BP_BHT_ENTRIES 64

// target buffer entries, direct mapped
`define BP_BTB_ENTRIES 16

// return address stack depth
`define BP_RAS_DEPTH 4

`endif

/* design/bpred_pkg.sv */
`include "bpred_consts.svh"

package bpred_pkg;

  // ------------------------------------------------------------
  // address types
  // ------------------------------------------------------------

  // one virtual address
  typedef logic [`BP_VLEN-1:0] vaddr_t;

  // one address per fetch slot, slot 0 in the low bits
  typedef logic [`BP_INSTR_PER_FETCH*`BP_VLEN-1:0] slot_addr_t;

  // ------------------------------------------------------------
  // prediction types
  // ------------------------------------------------------------

  // two bit saturating counter, upper bit means taken
  typedef logic [1:0] sat_cnt_t;

  // one bit per fetch slot
  typedef logic [`BP_INSTR_PER_FETCH-1:0] slot_mask_t;

endpackage

/* design/bht.sv */
`timescale 1ns/1ps

`include "bpred_consts.svh"

// branch history table
// two bit saturating counters, one prediction per halfword slot
module bht #(
  parameter int unsigned NR_ENTRIES = `BP_BHT_ENTRIES
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  debug_mode_i,
  input  bpred_pkg::vaddr_t     vpc_i,
  input  logic                  bht_update_valid_i,
  input  bpred_pkg::vaddr_t     bht_update_pc_i,
  input  logic                  bht_update_taken_i,
  output bpred_pkg::slot_mask_t bht_valid_o,
  output bpred_pkg::slot_mask_t bht_taken_o
);

  localparam int unsigned NR_SLOTS = `BP_INSTR_PER_FETCH;
  localparam int unsigned NR_ROWS = NR_ENTRIES / NR_SLOTS;
  // bit 0 of a halfword address is always zero
  localparam int unsigned OFFSET = 1;
  localparam int unsigned SLOT_BITS = $clog2(NR_SLOTS);
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);
  // highest address bit taking part in indexing, plus one
  localparam int unsigned PRED_BITS = ROW_BITS + SLOT_BITS + OFFSET;

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  logic                valid_q [NR_ROWS][NR_SLOTS];
  bpred_pkg::sat_cnt_t cnt_q   [NR_ROWS][NR_SLOTS];

  logic [ROW_BITS-1:0]  lookup_row;
  logic [ROW_BITS-1:0]  update_row;
  logic [SLOT_BITS-1:0] update_slot;
  logic                 update_en;
  bpred_pkg::sat_cnt_t  cnt_cur;
  bpred_pkg::sat_cnt_t  cnt_next;

  // row from the upper pc bits, slot from pc bit 1
  assign lookup_row  = vpc_i[PRED_BITS-1:SLOT_BITS+OFFSET];
  assign update_row  = bht_update_pc_i[PRED_BITS-1:SLOT_BITS+OFFSET];
  assign update_slot = bht_update_pc_i[SLOT_BITS+OFFSET-1:OFFSET];

  // no learning while the core is halted in debug
  assign update_en = bht_update_valid_i & ~debug_mode_i;

  // ------------------------------------------------------------
  // lookup, both slots of one row at once
  // ------------------------------------------------------------

  for (genvar i = 0; i < NR_SLOTS; i++) begin : gen_lookup
    assign bht_valid_o[i] = valid_q[lookup_row][i];
    assign bht_taken_o[i] = cnt_q[lookup_row][i][1];
  end

  // ------------------------------------------------------------
  // counter update for the single resolved entry
  // ------------------------------------------------------------

  assign cnt_cur = cnt_q[update_row][update_slot];

  always_comb begin
    cnt_next = cnt_cur;
    if (bht_update_taken_i) begin
      // saturate at strongly taken
      if (cnt_cur != 2'b11) begin
        cnt_next = cnt_cur + 2'd1;
      end
    end else begin
      // saturate at strongly not taken
      if (cnt_cur != 2'b00) begin
        cnt_next = cnt_cur - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < NR_SLOTS; s++) begin
          valid_q[r][s] <= 1'b0;
          cnt_q[r][s]   <= 2'b00;
        end
      end
    end else if (flush_i) begin
      // evict everything, counters restart weakly taken
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < NR_SLOTS; s++) begin
          valid_q[r][s] <= 1'b0;
          cnt_q[r][s]   <= 2'b10;
        end
      end
    end else if (update_en) begin
      valid_q[update_row][update_slot] <= 1'b1;
      cnt_q[update_row][update_slot]   <= cnt_next;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // resolved branches come from the back end on halfword boundaries
  a_update_pc_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bht_update_valid_i |-> !bht_update_pc_i[0]
  ) else $error("bht update pc is not halfword aligned");

endmodule

/* design/btb.sv */
`timescale 1ns/1ps

`include "bpred_consts.svh"

// direct mapped branch target buffer, one target per halfword slot
module btb #(
  parameter int unsigned NR_ENTRIES = `BP_BTB_ENTRIES
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  debug_mode_i,
  input  bpred_pkg::vaddr_t     vpc_i,
  input  logic                  btb_update_valid_i,
  input  bpred_pkg::vaddr_t     btb_update_pc_i,
  input  bpred_pkg::vaddr_t     btb_update_target_i,
  output bpred_pkg::slot_mask_t btb_valid_o,
  output bpred_pkg::slot_addr_t btb_target_o
);

  localparam int unsigned NR_SLOTS = `BP_INSTR_PER_FETCH;
  localparam int unsigned VLEN = `BP_VLEN;
  localparam int unsigned OFFSET = 1;
  localparam int unsigned SLOT_BITS = $clog2(NR_SLOTS);
  localparam int unsigned IDX_BITS = $clog2(NR_ENTRIES);
  localparam int unsigned ROW_BITS = IDX_BITS - SLOT_BITS;

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  logic [NR_ENTRIES-1:0] valid_q;
  bpred_pkg::vaddr_t     target_q [NR_ENTRIES];

  logic [ROW_BITS-1:0] lookup_row;
  logic [IDX_BITS-1:0] update_idx;
  logic                update_en;

  // entry index is {row, slot}, so pc bits above bit 0 map straight in
  assign lookup_row = vpc_i[IDX_BITS+OFFSET-1:SLOT_BITS+OFFSET];
  assign update_idx = btb_update_pc_i[IDX_BITS+OFFSET-1:OFFSET];

  // a flush in the same cycle wins over the update
  assign update_en = btb_update_valid_i & ~debug_mode_i & ~flush_i;

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------

  for (genvar i = 0; i < NR_SLOTS; i++) begin : gen_lookup
    logic [IDX_BITS-1:0] slot_idx;

    assign slot_idx = {lookup_row, SLOT_BITS'(i)};
    assign btb_valid_o[i] = valid_q[slot_idx];
    assign btb_target_o[i*VLEN +: VLEN] = target_q[slot_idx];
  end

  // ------------------------------------------------------------
  // update
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_en) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_en) begin
      target_q[update_idx] <= btb_update_target_i;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // jump targets land on halfword boundaries with compressed code
  a_update_target_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    btb_update_valid_i |-> !btb_update_target_i[0]
  ) else $error("btb update target is not halfword aligned");

endmodule

/* design/ras.sv */
`timescale 1ns/1ps

`include "bpred_consts.svh"

// return address stack, entry 0 is the top
module ras #(
  parameter int unsigned DEPTH = `BP_RAS_DEPTH
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ras_push_i,
  input  logic              ras_pop_i,
  input  bpred_pkg::vaddr_t ras_push_addr_i,
  output logic              ras_valid_o,
  output bpred_pkg::vaddr_t ras_addr_o
);

  logic [DEPTH-1:0]  valid_q;
  logic [DEPTH-1:0]  valid_d;
  bpred_pkg::vaddr_t addr_q [DEPTH];
  bpred_pkg::vaddr_t addr_d [DEPTH];

  // ------------------------------------------------------------
  // next stack contents
  // ------------------------------------------------------------

  always_comb begin
    valid_d = valid_q;
    addr_d  = addr_q;
    if (ras_push_i && ras_pop_i) begin
      // return followed by a call, overwrite the top in place
      valid_d[0] = 1'b1;
      addr_d[0]  = ras_push_addr_i;
    end else if (ras_push_i) begin
      // shift down, the oldest entry falls off the bottom
      valid_d   = {valid_q[DEPTH-2:0], 1'b1};
      addr_d[0] = ras_push_addr_i;
      for (int i = 1; i < DEPTH; i++) begin
        addr_d[i] = addr_q[i-1];
      end
    end else if (ras_pop_i && valid_q[0]) begin
      // shift up and free the last slot
      valid_d = {1'b0, valid_q[DEPTH-1:1]};
      for (int i = 0; i < DEPTH - 1; i++) begin
        addr_d[i] = addr_q[i+1];
      end
      addr_d[DEPTH-1] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        addr_q[i] <= '0;
      end
    end else begin
      valid_q <= valid_d;
      addr_q  <= addr_d;
    end
  end

  assign ras_valid_o = valid_q[0];
  assign ras_addr_o  = addr_q[0];

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // valid entries form one run starting at the top, i.e. 0..011..1
  a_valid_contiguous : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_q & (valid_q + 1'b1)) == '0
  ) else $error("ras valid bits have a hole");

endmodule

/* design/branch_predictor.sv */
`timescale 1ns/1ps

`include "bpred_consts.svh"

// branch prediction block of the fetch stage
// each predictor reports its own result, selection happens downstream
module branch_predictor (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  debug_mode_i,
  input  bpred_pkg::vaddr_t     vpc_i,
  // history table update from the back end
  input  logic                  bht_update_valid_i,
  input  bpred_pkg::vaddr_t     bht_update_pc_i,
  input  logic                  bht_update_taken_i,
  // target buffer update from the back end
  input  logic                  btb_update_valid_i,
  input  bpred_pkg::vaddr_t     btb_update_pc_i,
  input  bpred_pkg::vaddr_t     btb_update_target_i,
  // call and return tracking
  input  logic                  ras_push_i,
  input  logic                  ras_pop_i,
  input  bpred_pkg::vaddr_t     ras_push_addr_i,
  // predictions
  output bpred_pkg::slot_mask_t bht_valid_o,
  output bpred_pkg::slot_mask_t bht_taken_o,
  output bpred_pkg::slot_mask_t btb_valid_o,
  output bpred_pkg::slot_addr_t btb_target_o,
  output logic                  ras_valid_o,
  output bpred_pkg::vaddr_t     ras_addr_o
);

  // ------------------------------------------------------------
  // direction
  // ------------------------------------------------------------

  bht #(
    .NR_ENTRIES (`BP_BHT_ENTRIES)
  ) u_bht (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .debug_mode_i       (debug_mode_i),
    .vpc_i              (vpc_i),
    .bht_update_valid_i (bht_update_valid_i),
    .bht_update_pc_i    (bht_update_pc_i),
    .bht_update_taken_i (bht_update_taken_i),
    .bht_valid_o        (bht_valid_o),
    .bht_taken_o        (bht_taken_o)
  );

  // ------------------------------------------------------------
  // targets
  // ------------------------------------------------------------

  btb #(
    .NR_ENTRIES (`BP_BTB_ENTRIES)
  ) u_btb (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .debug_mode_i        (debug_mode_i),
    .vpc_i               (vpc_i),
    .btb_update_valid_i  (btb_update_valid_i),
    .btb_update_pc_i     (btb_update_pc_i),
    .btb_update_target_i (btb_update_target_i),
    .btb_valid_o         (btb_valid_o),
    .btb_target_o        (btb_target_o)
  );

  // return addresses are not flushed, they follow the call nesting
  ras #(
    .DEPTH (`BP_RAS_DEPTH)
  ) u_ras (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ras_push_i      (ras_push_i),
    .ras_pop_i       (ras_pop_i),
    .ras_push_addr_i (ras_push_addr_i),
    .ras_valid_o     (ras_valid_o),
    .ras_addr_o      (ras_addr_o)
  );

endmodule

/* verif/branch_predictor_tb.sv */
`timescale 1ns/1ps

`include "bpred_consts.svh"

module branch_predictor_tb;

  localparam int CLK_HALF     = 20;
  localparam int CHECK_DELAY  = 5;
  localparam int RESET_CYCLES = 16;
  localparam int NR_SLOTS     = `BP_INSTR_PER_FETCH;
  localparam int NR_ROWS      = `BP_BHT_ENTRIES / `BP_INSTR_PER_FETCH;
  localparam int BTB_ENTRIES  = `BP_BTB_ENTRIES;
  localparam int RAS_DEPTH    = `BP_RAS_DEPTH;
  localparam int VLEN         = `BP_VLEN;

  // test lengths in cycles
  localparam int IDLE_LOOKUPS  = 64;
  localparam int SAT_CYCLES    = 24;
  localparam int MIX_CYCLES    = 1200;
  localparam int DEBUG_UPDATES = 40;
  localparam int FLUSH_CYCLES  = 2 * NR_ROWS + 8;
  localparam int RAS_DIRECTED  = 24;
  localparam int RAS_CYCLES    = 600;
  localparam int TEST_CYCLES   = RESET_CYCLES + IDLE_LOOKUPS + SAT_CYCLES + MIX_CYCLES +
                                 DEBUG_UPDATES + FLUSH_CYCLES + RAS_DIRECTED + RAS_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  debug_mode_i;
  bpred_pkg::vaddr_t     vpc_i;
  logic                  bht_update_valid_i;
  bpred_pkg::vaddr_t     bht_update_pc_i;
  logic                  bht_update_taken_i;
  logic                  btb_update_valid_i;
  bpred_pkg::vaddr_t     btb_update_pc_i;
  bpred_pkg::vaddr_t     btb_update_target_i;
  logic                  ras_push_i;
  logic                  ras_pop_i;
  bpred_pkg::vaddr_t     ras_push_addr_i;
  bpred_pkg::slot_mask_t bht_valid_o;
  bpred_pkg::slot_mask_t bht_taken_o;
  bpred_pkg::slot_mask_t btb_valid_o;
  bpred_pkg::slot_addr_t btb_target_o;
  logic                  ras_valid_o;
  bpred_pkg::vaddr_t     ras_addr_o;

  // reference state
  logic                ref_bht_valid [NR_ROWS][NR_SLOTS];
  bpred_pkg::sat_cnt_t ref_bht_cnt   [NR_ROWS][NR_SLOTS];
  logic                ref_btb_valid [BTB_ENTRIES];
  bpred_pkg::vaddr_t   ref_btb_target [BTB_ENTRIES];
  bpred_pkg::vaddr_t   ref_ras_addr  [RAS_DEPTH];
  int                  ref_ras_count;

  int                  cycle_count = 0;
  bpred_pkg::vaddr_t   last_bht_pc = '0;

  branch_predictor u_branch_predictor (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .debug_mode_i        (debug_mode_i),
    .vpc_i               (vpc_i),
    .bht_update_valid_i  (bht_update_valid_i),
    .bht_update_pc_i     (bht_update_pc_i),
    .bht_update_taken_i  (bht_update_taken_i),
    .btb_update_valid_i  (btb_update_valid_i),
    .btb_update_pc_i     (btb_update_pc_i),
    .btb_update_target_i (btb_update_target_i),
    .ras_push_i          (ras_push_i),
    .ras_pop_i           (ras_pop_i),
    .ras_push_addr_i     (ras_push_addr_i),
    .bht_valid_o         (bht_valid_o),
    .bht_taken_o         (bht_taken_o),
    .btb_valid_o         (btb_valid_o),
    .btb_target_o        (btb_target_o),
    .ras_valid_o         (ras_valid_o),
    .ras_addr_o          (ras_addr_o)
  );

  always #(CLK_HALF) clk_i = ~clk_i;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic bpred_pkg::sat_cnt_t count_after(input bpred_pkg::sat_cnt_t cnt,
                                                      input logic taken);
    if (taken) begin
      return (cnt == 2'd3) ? 2'd3 : cnt + 2'd1;
    end
    return (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
  endfunction

  function void reset_reference();
    for (int r = 0; r < NR_ROWS; r++) begin
      for (int s = 0; s < NR_SLOTS; s++) begin
        ref_bht_valid[r][s] = 1'b0;
        ref_bht_cnt[r][s]   = 2'd0;
      end
    end
    for (int e = 0; e < BTB_ENTRIES; e++) begin
      ref_btb_valid[e] = 1'b0;
    end
    for (int d = 0; d < RAS_DEPTH; d++) begin
      ref_ras_addr[d] = '0;
    end
    ref_ras_count = 0;
  endfunction

  // one clock edge of table, buffer and stack from the inputs before the edge
  function void step_reference();
    logic [4:0] row;
    logic       slot;
    logic [3:0] idx;
    if (flush_i) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < NR_SLOTS; s++) begin
          ref_bht_valid[r][s] = 1'b0;
          ref_bht_cnt[r][s]   = 2'd2;
        end
      end
      for (int e = 0; e < BTB_ENTRIES; e++) begin
        ref_btb_valid[e] = 1'b0;
      end
    end else if (!debug_mode_i) begin
      if (bht_update_valid_i) begin
        row  = bht_update_pc_i[6:2];
        slot = bht_update_pc_i[1];
        ref_bht_valid[row][slot] = 1'b1;
        ref_bht_cnt[row][slot]   = count_after(ref_bht_cnt[row][slot], bht_update_taken_i);
      end
      if (btb_update_valid_i) begin
        idx = btb_update_pc_i[4:1];
        ref_btb_valid[idx]  = 1'b1;
        ref_btb_target[idx] = btb_update_target_i;
      end
    end
    if (ras_push_i && ras_pop_i) begin
      ref_ras_addr[0] = ras_push_addr_i;
      if (ref_ras_count == 0) begin
        ref_ras_count = 1;
      end
    end else if (ras_push_i) begin
      for (int i = RAS_DEPTH - 1; i > 0; i--) begin
        ref_ras_addr[i] = ref_ras_addr[i-1];
      end
      ref_ras_addr[0] = ras_push_addr_i;
      if (ref_ras_count < RAS_DEPTH) begin
        ref_ras_count++;
      end
    end else if (ras_pop_i && ref_ras_count > 0) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        ref_ras_addr[i] = ref_ras_addr[i+1];
      end
      ref_ras_count--;
    end
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_mask(input string name, input bpred_pkg::slot_mask_t actual,
                            input bpred_pkg::slot_mask_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic check_addr(input string name, input bpred_pkg::vaddr_t actual,
                            input bpred_pkg::vaddr_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
    end
  endtask

  // targets are compared only for the slots set in care
  task automatic check_slot_addr(input string name, input bpred_pkg::slot_addr_t actual,
                                 input bpred_pkg::slot_addr_t expected,
                                 input bpred_pkg::slot_mask_t care);
    for (int s = 0; s < NR_SLOTS; s++) begin
      if (care[s] && actual[s*VLEN +: VLEN] !== expected[s*VLEN +: VLEN]) begin
        stop_on_error($sformatf("mismatch %s slot %0d: got %h expected %h", name, s,
                                actual[s*VLEN +: VLEN], expected[s*VLEN +: VLEN]));
      end
    end
  endtask

  task automatic check_outputs();
    logic [4:0]            row;
    logic [2:0]            btb_row;
    bpred_pkg::slot_mask_t exp_bht_valid;
    bpred_pkg::slot_mask_t exp_bht_taken;
    bpred_pkg::slot_mask_t exp_btb_valid;
    bpred_pkg::slot_addr_t exp_target;
    row     = vpc_i[6:2];
    btb_row = vpc_i[4:2];
    exp_target = '0;
    for (int s = 0; s < NR_SLOTS; s++) begin
      exp_bht_valid[s] = ref_bht_valid[row][s];
      exp_bht_taken[s] = ref_bht_cnt[row][s][1];
      exp_btb_valid[s] = ref_btb_valid[{btb_row, s[0]}];
      exp_target[s*VLEN +: VLEN] = ref_btb_target[{btb_row, s[0]}];
    end
    check_mask("bht_valid_o", bht_valid_o, exp_bht_valid);
    check_mask("bht_taken_o", bht_taken_o, exp_bht_taken);
    check_mask("btb_valid_o", btb_valid_o, exp_btb_valid);
    check_slot_addr("btb_target_o", btb_target_o, exp_target, exp_btb_valid);
    check_bit("ras_valid_o", ras_valid_o, ref_ras_count != 0);
    if (ref_ras_count != 0) begin
      check_addr("ras_addr_o", ras_addr_o, ref_ras_addr[0]);
    end
  endtask

  // reference follows every edge and outputs are compared once they settle
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      reset_reference();
    end else begin
      step_reference();
    end
    #(CHECK_DELAY);
    if (rst_ni) begin
      check_outputs();
    end
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout: run did not finish within %0d cycles",
                              TIMEOUT_CYCLES));
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  function automatic bpred_pkg::vaddr_t random_addr();
    bpred_pkg::vaddr_t addr;
    addr    = $urandom;
    addr[0] = 1'b0;
    return addr;
  endfunction

  task automatic drive_cycle(input bpred_pkg::vaddr_t pc, input logic flush,
                             input logic debug, input logic bht_v,
                             input bpred_pkg::vaddr_t bht_pc, input logic bht_taken,
                             input logic btb_v, input bpred_pkg::vaddr_t btb_pc,
                             input bpred_pkg::vaddr_t btb_target, input logic push,
                             input logic pop, input bpred_pkg::vaddr_t push_addr);
    @(posedge clk_i);
    vpc_i               <= pc;
    flush_i             <= flush;
    debug_mode_i        <= debug;
    bht_update_valid_i  <= bht_v;
    bht_update_pc_i     <= bht_pc;
    bht_update_taken_i  <= bht_taken;
    btb_update_valid_i  <= btb_v;
    btb_update_pc_i     <= btb_pc;
    btb_update_target_i <= btb_target;
    ras_push_i          <= push;
    ras_pop_i           <= pop;
    ras_push_addr_i     <= push_addr;
  endtask

  task automatic lookup_cycle(input bpred_pkg::vaddr_t pc);
    drive_cycle(pc, 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic bht_train_cycle(input bpred_pkg::vaddr_t pc, input logic taken);
    drive_cycle(pc, 1'b0, 1'b0, 1'b1, pc, taken, 1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic ras_cycle(input logic push, input logic pop, input bpred_pkg::vaddr_t addr);
    drive_cycle(random_addr(), 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0, push, pop, addr);
  endtask

  task automatic random_mix_cycle();
    bpred_pkg::vaddr_t lookup_pc;
    bpred_pkg::vaddr_t bht_pc;
    bpred_pkg::vaddr_t btb_pc;
    lookup_pc = random_addr();
    bht_pc    = random_addr();
    btb_pc    = random_addr();
    // steer pcs into recently trained rows so aliasing is common
    if ($urandom_range(1, 0) == 1) begin
      lookup_pc[6:0] = last_bht_pc[6:0];
    end
    if ($urandom_range(3, 0) == 0) begin
      btb_pc[4:0] = last_bht_pc[4:0];
    end
    last_bht_pc = bht_pc;
    drive_cycle(lookup_pc, $urandom_range(127, 0) == 0, $urandom_range(15, 0) == 0,
                $urandom_range(1, 0) == 1, bht_pc, $urandom_range(1, 0) == 1,
                $urandom_range(1, 0) == 1, btb_pc, random_addr(),
                1'b0, 1'b0, '0);
  endtask

  initial begin
    bpred_pkg::vaddr_t     pc;
    bpred_pkg::slot_mask_t slot_bit;
    bpred_pkg::vaddr_t     ras_seq [5];
    int unsigned           push_pct;

    void'($urandom(32'hd289));
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    debug_mode_i        = 1'b0;
    vpc_i               = '0;
    bht_update_valid_i  = 1'b0;
    bht_update_pc_i     = '0;
    bht_update_taken_i  = 1'b0;
    btb_update_valid_i  = 1'b0;
    btb_update_pc_i     = '0;
    btb_update_target_i = '0;
    ras_push_i          = 1'b0;
    ras_pop_i           = 1'b0;
    ras_push_addr_i     = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    // after reset nothing is valid and every counter is zero
    repeat (IDLE_LOOKUPS) begin
      lookup_cycle(random_addr());
      #(CHECK_DELAY);
      check_mask("bht_valid_o", bht_valid_o, '0);
      check_mask("bht_taken_o", bht_taken_o, '0);
      check_mask("btb_valid_o", btb_valid_o, '0);
      check_bit("ras_valid_o", ras_valid_o, 1'b0);
    end

    // counter walks 0 to 3 and back and reads taken while the upper bit is set
    pc       = random_addr();
    slot_bit = bpred_pkg::slot_mask_t'(1) << pc[1];
    for (int k = 1; k <= 5; k++) begin
      bht_train_cycle(pc, 1'b1);
      lookup_cycle(pc);
      #(CHECK_DELAY);
      check_mask("bht_valid_o", bht_valid_o & slot_bit, slot_bit);
      check_mask("bht_taken_o", bht_taken_o & slot_bit, (k >= 2) ? slot_bit : '0);
    end
    for (int j = 1; j <= 5; j++) begin
      bht_train_cycle(pc, 1'b0);
      lookup_cycle(pc);
      #(CHECK_DELAY);
      check_mask("bht_taken_o", bht_taken_o & slot_bit, (j < 2) ? slot_bit : '0);
    end

    repeat (MIX_CYCLES) random_mix_cycle();

    // updates in debug mode are dropped
    repeat (DEBUG_UPDATES) begin
      drive_cycle(random_addr(), 1'b0, 1'b1, 1'b1, random_addr(), $urandom_range(1, 0) == 1,
                  1'b1, random_addr(), random_addr(), 1'b0, 1'b0, '0);
    end

    // flush with competing updates and then every row reads weakly taken and invalid
    drive_cycle(random_addr(), 1'b1, 1'b0, 1'b1, random_addr(), 1'b0,
                1'b1, random_addr(), random_addr(), 1'b0, 1'b0, '0);
    for (int r = 0; r < NR_ROWS; r++) begin
      lookup_cycle(bpred_pkg::vaddr_t'(r << 2));
      #(CHECK_DELAY);
      check_mask("bht_valid_o", bht_valid_o, '0);
      check_mask("bht_taken_o", bht_taken_o, '1);
      check_mask("btb_valid_o", btb_valid_o, '0);
    end
    pc       = random_addr();
    slot_bit = bpred_pkg::slot_mask_t'(1) << pc[1];
    bht_train_cycle(pc, 1'b1);
    lookup_cycle(pc);
    #(CHECK_DELAY);
    check_mask("bht_valid_o", bht_valid_o & slot_bit, slot_bit);
    check_mask("bht_taken_o", bht_taken_o & slot_bit, slot_bit);

    // ------------------------------------------------------------
    // overflow of the return stack drops the oldest of five calls
    // ------------------------------------------------------------

    for (int n = 0; n < 5; n++) begin
      ras_seq[n] = 32'h8000_0000 | bpred_pkg::vaddr_t'(n << 2);
      ras_cycle(1'b1, 1'b0, ras_seq[n]);
    end
    ras_cycle(1'b0, 1'b0, '0);
    #(CHECK_DELAY);
    check_addr("ras_addr_o", ras_addr_o, ras_seq[4]);
    for (int n = 3; n >= 0; n--) begin
      ras_cycle(1'b0, 1'b1, '0);
      ras_cycle(1'b0, 1'b0, '0);
      #(CHECK_DELAY);
      check_bit("ras_valid_o", ras_valid_o, n != 0);
      if (n != 0) begin
        check_addr("ras_addr_o", ras_addr_o, ras_seq[n]);
      end
    end

    // random calls and returns with push heavy first and pop heavy later
    for (int c = 0; c < RAS_CYCLES; c++) begin
      push_pct = (c < RAS_CYCLES / 2) ? 65 : 35;
      ras_cycle($urandom_range(99, 0) < push_pct, $urandom_range(99, 0) >= push_pct,
                random_addr());
    end
    lookup_cycle('0);
    @(posedge clk_i);
    #(CHECK_DELAY);

    $display("Test passed");
    $finish;
  end

endmodule

/* branch_predictor.f */
+incdir+.
design/bpred_pkg.sv
design/bht.sv
design/btb.sv
design/ras.sv
design/branch_predictor.sv
verif/branch_predictor_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --top-module branch_predictor_tb \
  -f branch_predictor.f -o sim_branch_predictor > "$LOG" 2>&1 &&
  ./obj_dir/sim_branch_predictor >> "$LOG" 2>&1 ||
  echo "Test failed" >> "$LOG"

cat "$LOG"
grep -q "Test failed" "$LOG" && exit 1
exit 0
